//--- common/rv_core_pkg.sv
`default_nettype none

`include "rv_core_settings.svh"

package rv_core_pkg;

  // One data or address word
  typedef logic [`RV_XLEN-1:0] word_t;

  // Register index
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

  // --------------------------------------------------------------------------
  // Stage to stage bundles
  // --------------------------------------------------------------------------

  // Fetched word paired with its address
  typedef struct packed {
    word_t instr;
    word_t pc;
  } fetch_t;

  // Decoded instruction with operands already read
  typedef struct packed {
    reg_addr_t rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    word_t     pc;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_branch;
    logic      branch_ne;
    logic      is_jal;
    logic      is_lui;
    logic      use_imm;
    logic      sub;
    logic      is_ebreak;
    logic      illegal;
  } decoded_t;

  // Execute result, address for loads and stores
  typedef struct packed {
    word_t     result;
    word_t     store_data;
    reg_addr_t rd;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_ebreak;
    logic      illegal;
  } exec_t;

  // Register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     data;
  } rf_write_t;

endpackage

`default_nettype wire

//--- common/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Datapath width and register count
`define RV_XLEN 32
`define RV_NUM_REGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Major opcodes of the supported subset
`define RV_OP_LUI 7'b0110111
`define RV_OP_OPIMM 7'b0010011
`define RV_OP_OP 7'b0110011
`define RV_OP_LOAD 7'b0000011
`define RV_OP_STORE 7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL 7'b1101111
`define RV_OP_SYSTEM 7'b1110011

// funct3 / funct7 selectors
`define RV_F3_ADD 3'b000
`define RV_F3_WORD 3'b010
`define RV_F3_BEQ 3'b000
`define RV_F3_BNE 3'b001
`define RV_F7_ADD 7'b0000000
`define RV_F7_SUB 7'b0100000

// Only SYSTEM word accepted
`define RV_EBREAK_WORD 32'h0010_0073

`endif

//--- decode/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_decode import rv_core_pkg::*; (
  input  fetch_t    fetch,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output decoded_t  dec
);

  // --------------------------------------------------------------------------
  // Field extraction
  // --------------------------------------------------------------------------
  word_t     instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t rd;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_u;
  word_t     imm_j;

  assign instr  = fetch.instr;
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Register reads go straight to the regfile
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // --------------------------------------------------------------------------
  // Control decode
  // --------------------------------------------------------------------------
  always_comb begin
    // All flags off unless an accepted encoding sets them
    dec          = '0;
    dec.rd       = rd;
    dec.rs1_data = rs1_data;
    dec.rs2_data = rs2_data;
    dec.pc       = fetch.pc;
    case (opcode)
      `RV_OP_LUI: begin
        dec.imm       = imm_u;
        dec.is_lui    = 1'b1;
        dec.reg_write = 1'b1;
      end
      `RV_OP_OPIMM: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.reg_write = (funct3 == `RV_F3_ADD);
        dec.illegal   = (funct3 != `RV_F3_ADD);
      end
      `RV_OP_OP: begin
        // ADD and SUB only, both with funct3 zero
        if (funct3 == `RV_F3_ADD && (funct7 == `RV_F7_ADD || funct7 == `RV_F7_SUB)) begin
          dec.reg_write = 1'b1;
          dec.sub       = (funct7 == `RV_F7_SUB);
        end else begin
          dec.illegal = 1'b1;
        end
      end
      `RV_OP_LOAD: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.mem_read  = (funct3 == `RV_F3_WORD);
        dec.reg_write = (funct3 == `RV_F3_WORD);
        dec.illegal   = (funct3 != `RV_F3_WORD);
      end
      `RV_OP_STORE: begin
        dec.imm       = imm_s;
        dec.use_imm   = 1'b1;
        dec.mem_write = (funct3 == `RV_F3_WORD);
        dec.illegal   = (funct3 != `RV_F3_WORD);
      end
      `RV_OP_BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = (funct3 == `RV_F3_BEQ || funct3 == `RV_F3_BNE);
        dec.branch_ne = (funct3 == `RV_F3_BNE);
        dec.illegal   = !(funct3 == `RV_F3_BEQ || funct3 == `RV_F3_BNE);
      end
      `RV_OP_JAL: begin
        dec.imm       = imm_j;
        dec.is_jal    = 1'b1;
        dec.reg_write = 1'b1;
      end
      `RV_OP_SYSTEM: begin
        // EBREAK is the only system word, it writes nothing
        dec.is_ebreak = (instr == `RV_EBREAK_WORD);
        dec.illegal   = (instr != `RV_EBREAK_WORD);
      end
      default: dec.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- decode/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_regfile import rv_core_pkg::*; (
  input  logic      clk,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  rf_write_t wr
);

  // x1..x31 only, x0 has no storage
  word_t [`RV_NUM_REGS-1:1] regs;

  // Synchronous write, dropped for x0
  always_ff @(posedge clk) begin
    if (wr.we && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // Combinational reads, x0 reads as zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // A write aimed at x0 leaves the whole array untouched on that edge
  assert property (@(posedge clk) (wr.we && wr.rd == '0) |=> $stable(regs))
    else $error("rv_regfile: write to x0 altered the register array");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module rv_core_tb \
  --Mdir "$BUILD_DIR" -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/rv_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim/rv_program_rom.svh
`ifndef RV_PROGRAM_ROM_SVH
`define RV_PROGRAM_ROM_SVH

// Encoders for the RV32I subset run by the test programs
// Field order follows the base ISA formats, opcodes spelled out in binary

// U-type, upper 20 bits of the result
function automatic word_t lui_insn(input reg_addr_t rd, input logic [19:0] imm);
  return {imm, rd, 7'b0110111};
endfunction

function automatic word_t addi_insn(input reg_addr_t rd, input reg_addr_t rs1,
                                    input logic [11:0] imm);
  return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

// R-type, funct7 bit 30 turns ADD into SUB
function automatic word_t op_insn(input logic sub, input reg_addr_t rd,
                                  input reg_addr_t rs1, input reg_addr_t rs2);
  return {1'b0, sub, 5'b00000, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

function automatic word_t lw_insn(input reg_addr_t rd, input reg_addr_t rs1,
                                  input logic [11:0] imm);
  return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

// S-type, offset split around rs1/rs2
function automatic word_t sw_insn(input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

// B-type, funct3 000 for BEQ and 001 for BNE
function automatic word_t branch_insn(input logic [2:0] f3, input reg_addr_t rs1,
                                      input reg_addr_t rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic word_t jal_insn(input reg_addr_t rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic word_t ebreak_insn();
  return 32'h0010_0073;
endfunction

`endif

//--- sim/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_core_tb import rv_core_pkg::*; ();

  // Six directed tests with a 64-cycle budget each
  localparam int CYCLE_LIMIT = 6 * 64;

  logic       clk;
  logic       rst_n;
  word_t      imem_raddr, imem_rdata;
  word_t      dmem_raddr, dmem_rdata, dmem_waddr, dmem_wdata;
  logic       dmem_ren, dmem_we, ebreak, trap;
  logic [3:0] dmem_wstrb;

  // Word-addressed memories, 256 words each
  word_t imem [256];
  word_t dmem [256];

  // Program under test, stores seen on the bus, stores expected
  word_t prog [$];
  word_t wr_addr_q [$];
  word_t wr_data_q [$];
  word_t exp_addr_q [$];
  word_t exp_data_q [$];

  int     ren_count;
  int     cycle_count = 0;
  int     errors;
  int     errors_at_start;
  int     passed;
  int     failed;
  integer seed;

  `include "rv_program_rom.svh"

  rv_core uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_ren  (dmem_ren),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Zero-latency reads
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_raddr[9:2]];

  // --------------------------------------------------------------------------
  // Bus monitor and timeout
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      wr_addr_q.delete();
      wr_data_q.delete();
      ren_count <= 0;
    end else begin
      if (dmem_we) begin
        // Only full-word stores exist
        check_value("store strobes", {28'd0, dmem_wstrb}, 32'h0000_000f);
        wr_addr_q.push_back(dmem_waddr);
        wr_data_q.push_back(dmem_wdata);
        dmem[dmem_waddr[9:2]] = dmem_wdata;
      end
      if (dmem_ren) begin
        ren_count <= ren_count + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the core never halted", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // Stray fetches land on opcode 7f and trap
  function automatic word_t imem_fill(input int i);
    return {16'hdead, i[7:0], 8'h7f};
  endfunction

  function automatic word_t dmem_fill(input int i);
    return {16'h5a5a, ~i[7:0], i[7:0]};
  endfunction

  task automatic check_value(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic fill_memories();
    for (int i = 0; i < 256; i++) begin
      imem[i] = imem_fill(i);
      dmem[i] = dmem_fill(i);
    end
  endtask

  task automatic start_test();
    errors_at_start = errors;
    prog.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
  endtask

  // SW off(x0) plus the write it must produce, offsets kept below 0x800
  task automatic store_expect(input reg_addr_t rs, input logic [11:0] off, input word_t value);
    prog.push_back(sw_insn(rs, 5'd0, off));
    exp_addr_q.push_back({20'd0, off});
    exp_data_q.push_back(value);
  endtask

  task automatic load_and_reset();
    @(negedge clk);
    rst_n = 1'b0;
    fill_memories();
    foreach (prog[i])
      imem[i] = prog[i];
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic run_to_halt();
    while (!(ebreak || trap)) begin
      @(negedge clk);
    end
    // Extra cycles so a store after halt would show up in the log
    repeat (4) @(negedge clk);
  endtask

  task automatic compare_log();
    check_value("store count", word_t'(wr_addr_q.size()), word_t'(exp_addr_q.size()));
    for (int i = 0; i < wr_addr_q.size() && i < exp_addr_q.size(); i++) begin
      check_value($sformatf("store %0d address", i), wr_addr_q[i], exp_addr_q[i]);
      check_value($sformatf("store %0d data", i), wr_data_q[i], exp_data_q[i]);
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      passed++;
      $display("%s: pass", name);
    end else begin
      failed++;
      $display("%s: FAIL with %0d errors", name, errors - errors_at_start);
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic arithmetic_test();
    logic [31:0] r;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [19:0] upper;
    word_t       a;
    word_t       b;
    word_t       hi;
    start_test();
    r = $random(seed);
    imm_a = r[11:0];
    imm_b = r[23:12];
    r = $random(seed);
    // Top bit set so hi + hi wraps
    upper = r[19:0] | 20'h80000;
    a = sext12(imm_a);
    b = sext12(imm_b);
    hi = {upper, 12'h000};
    prog.push_back(addi_insn(5'd1, 5'd0, imm_a));
    prog.push_back(addi_insn(5'd2, 5'd0, imm_b));
    prog.push_back(op_insn(1'b0, 5'd3, 5'd1, 5'd2));
    prog.push_back(op_insn(1'b1, 5'd4, 5'd1, 5'd2));
    prog.push_back(lui_insn(5'd5, upper));
    prog.push_back(addi_insn(5'd6, 5'd5, imm_a));
    prog.push_back(op_insn(1'b0, 5'd7, 5'd5, 5'd5));
    // Write to x0 is discarded
    prog.push_back(addi_insn(5'd0, 5'd0, 12'h07b));
    store_expect(5'd1, 12'h100, a);
    store_expect(5'd3, 12'h104, a + b);
    store_expect(5'd4, 12'h108, a - b);
    store_expect(5'd5, 12'h10c, hi);
    store_expect(5'd6, 12'h110, hi + a);
    store_expect(5'd7, 12'h114, hi + hi);
    store_expect(5'd0, 12'h118, 32'd0);
    prog.push_back(ebreak_insn());
    load_and_reset();
    run_to_halt();
    compare_log();
    finish_test("arithmetic");
  endtask

  task automatic round_trip_test();
    logic [31:0] r;
    word_t       value;
    start_test();
    r = $random(seed);
    value = {r[31:12], 12'h000} + sext12(r[11:0]);
    prog.push_back(lui_insn(5'd1, r[31:12]));
    prog.push_back(addi_insn(5'd1, 5'd1, r[11:0]));
    store_expect(5'd1, 12'h040, value);
    prog.push_back(lw_insn(5'd2, 5'd0, 12'h040));
    prog.push_back(addi_insn(5'd3, 5'd2, 12'h123));
    store_expect(5'd3, 12'h044, value + 32'h123);
    prog.push_back(ebreak_insn());
    load_and_reset();
    run_to_halt();
    compare_log();
    check_value("load strobes", word_t'(ren_count), 32'd1);
    finish_test("memory round trip");
  endtask

  task automatic branch_jump_test();
    start_test();
    prog.push_back(addi_insn(5'd1, 5'd0, 12'd5));
    prog.push_back(addi_insn(5'd2, 5'd0, 12'd5));
    // Taken BEQ hops over the store at 0x80
    prog.push_back(branch_insn(3'b000, 5'd1, 5'd2, 13'd8));
    prog.push_back(sw_insn(5'd1, 5'd0, 12'h080));
    prog.push_back(branch_insn(3'b001, 5'd1, 5'd2, 13'd8));
    store_expect(5'd2, 12'h084, 32'd5);
    // JAL at word 6 links 24 + 4 and skips the store at 0x88
    prog.push_back(jal_insn(5'd3, 21'd8));
    prog.push_back(sw_insn(5'd0, 5'd0, 12'h088));
    store_expect(5'd3, 12'h08c, 32'd24 + 32'd4);
    prog.push_back(ebreak_insn());
    load_and_reset();
    run_to_halt();
    compare_log();
    finish_test("control flow");
  endtask

  task automatic ebreak_halt_test();
    start_test();
    prog.push_back(addi_insn(5'd1, 5'd0, 12'd7));
    prog.push_back(ebreak_insn());
    prog.push_back(sw_insn(5'd1, 5'd0, 12'h020));
    load_and_reset();
    run_to_halt();
    check_value("ebreak", {31'd0, ebreak}, 32'd1);
    check_value("trap", {31'd0, trap}, 32'd0);
    check_value("halted pc", imem_raddr, 32'd4);
    compare_log();
    finish_test("ebreak halt");
  endtask

  task automatic illegal_halt_test();
    start_test();
    prog.push_back(addi_insn(5'd1, 5'd0, 12'd9));
    store_expect(5'd1, 12'h030, 32'd9);
    prog.push_back(32'hffff_ffff);
    prog.push_back(sw_insn(5'd1, 5'd0, 12'h034));
    load_and_reset();
    run_to_halt();
    check_value("trap", {31'd0, trap}, 32'd1);
    check_value("ebreak", {31'd0, ebreak}, 32'd0);
    check_value("halted pc", imem_raddr, 32'd8);
    compare_log();
    finish_test("illegal halt");
  endtask

  // Follows a trap, so the sticky flags must clear
  task automatic reset_state_test();
    start_test();
    prog.push_back(addi_insn(5'd1, 5'd0, 12'd1));
    prog.push_back(ebreak_insn());
    load_and_reset();
    check_value("pc after reset", imem_raddr, `RV_RESET_PC);
    check_value("ebreak after reset", {31'd0, ebreak}, 32'd0);
    check_value("trap after reset", {31'd0, trap}, 32'd0);
    check_value("dmem_we after reset", {31'd0, dmem_we}, 32'd0);
    check_value("dmem_ren after reset", {31'd0, dmem_ren}, 32'd0);
    run_to_halt();
    check_value("ebreak after run", {31'd0, ebreak}, 32'd1);
    // A second reset must drop the ebreak flag too
    load_and_reset();
    check_value("ebreak after second reset", {31'd0, ebreak}, 32'd0);
    check_value("pc after second reset", imem_raddr, `RV_RESET_PC);
    finish_test("reset");
  endtask

  initial begin
    rst_n  = 1'b0;
    seed   = 30;
    errors = 0;
    passed = 0;
    failed = 0;
    fill_memories();
    arithmetic_test();
    round_trip_test();
    branch_jump_test();
    ebreak_halt_test();
    illegal_halt_test();
    reset_state_test();
    $display("Summary: %0d tests passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
+incdir+sim
common/rv_core_pkg.sv
src/rv_fetch.sv
decode/rv_decode.sv
decode/rv_regfile.sv
src/rv_execute.sv
src/rv_writeback.sv
src/rv_core.sv
sim/rv_core_tb.sv

//--- src/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // Instruction memory
  output word_t      imem_raddr,
  input  word_t      imem_rdata,
  // Data memory read side
  output logic       dmem_ren,
  output word_t      dmem_raddr,
  input  word_t      dmem_rdata,
  // Data memory write side
  output logic       dmem_we,
  output word_t      dmem_waddr,
  output word_t      dmem_wdata,
  output logic [3:0] dmem_wstrb,
  // Sticky halt status
  output logic       ebreak,
  output logic       trap
);

  // --------------------------------------------------------------------------
  // Stage interconnect
  // --------------------------------------------------------------------------
  fetch_t    fetch;
  decoded_t  dec;
  exec_t     ex;
  rf_write_t rf_wr;
  word_t     next_pc;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      halted;

  rv_fetch u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .next_pc   (next_pc),
    .halted    (halted),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .fetch     (fetch)
  );

  rv_decode u_decode (
    .fetch   (fetch),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .dec     (dec)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .wr      (rf_wr)
  );

  // Next pc loops back to fetch
  rv_execute u_execute (
    .dec    (dec),
    .result (ex),
    .next_pc(next_pc)
  );

  rv_writeback u_writeback (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex        (ex),
    .dmem_raddr(dmem_raddr),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .dmem_ren  (dmem_ren),
    .dmem_we   (dmem_we),
    .dmem_wstrb(dmem_wstrb),
    .dmem_rdata(dmem_rdata),
    .rf_wr     (rf_wr),
    .halted    (halted),
    .ebreak    (ebreak),
    .trap      (trap)
  );

endmodule

`default_nettype wire

//--- src/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_core_pkg::*; (
  input  decoded_t dec,
  output exec_t    result,
  output word_t    next_pc
);

  // --------------------------------------------------------------------------
  // ALU and branch compare
  // --------------------------------------------------------------------------
  word_t op_b;
  word_t alu_out;
  word_t pc_plus4;
  word_t target;
  logic  rs_equal;
  logic  taken;
  logic  halt;

  // Immediate for ADDI, loads and stores, rs2 for ADD/SUB
  assign op_b    = dec.use_imm ? dec.imm : dec.rs2_data;
  assign alu_out = dec.sub ? (dec.rs1_data - op_b) : (dec.rs1_data + op_b);

  assign pc_plus4 = dec.pc + 32'd4;

  // Same pc-relative adder serves branches and JAL
  assign target = dec.pc + dec.imm;

  // BEQ takes on equal, BNE on not equal
  assign rs_equal = (dec.rs1_data == dec.rs2_data);
  assign taken    = dec.is_jal || (dec.is_branch && (rs_equal ^ dec.branch_ne));

  // Halting instruction keeps pc on itself
  assign halt = dec.is_ebreak || dec.illegal;

  // --------------------------------------------------------------------------
  // Next pc and result bundle
  // --------------------------------------------------------------------------
  always_comb begin
    if (halt) begin
      next_pc = dec.pc;
    end else if (taken) begin
      next_pc = target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_comb begin
    // LUI passes the immediate, JAL links pc+4
    if (dec.is_lui) begin
      result.result = dec.imm;
    end else if (dec.is_jal) begin
      result.result = pc_plus4;
    end else begin
      result.result = alu_out;
    end
    result.store_data = dec.rs2_data;
    result.rd         = dec.rd;
    result.reg_write  = dec.reg_write;
    result.mem_read   = dec.mem_read;
    result.mem_write  = dec.mem_write;
    result.is_ebreak  = dec.is_ebreak;
    result.illegal    = dec.illegal;
  end

endmodule

`default_nettype wire

//--- src/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_settings.svh"

module rv_fetch import rv_core_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  word_t  next_pc,
  input  logic   halted,
  output word_t  imem_raddr,
  input  word_t  imem_rdata,
  output fetch_t fetch
);

  // Program counter, the only state in the front end
  word_t pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else if (!halted) begin
      // Frozen once the core has halted
      pc <= next_pc;
    end
  end

  // Zero-latency instruction memory, read every cycle
  assign imem_raddr = pc;

  // Word and its own address travel together to decode
  assign fetch.instr = imem_rdata;
  assign fetch.pc    = pc;

  // Targets coming back from execute keep fetch on word boundaries
  assert property (@(posedge clk) disable iff (!rst_n) imem_raddr[1:0] == 2'b00)
    else $error("rv_fetch: misaligned fetch address %h", imem_raddr);

endmodule

`default_nettype wire

//--- src/rv_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module rv_writeback import rv_core_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  exec_t      ex,
  output word_t      dmem_raddr,
  output word_t      dmem_waddr,
  output word_t      dmem_wdata,
  output logic       dmem_ren,
  output logic       dmem_we,
  output logic [3:0] dmem_wstrb,
  input  word_t      dmem_rdata,
  output rf_write_t  rf_wr,
  output logic       halted,
  output logic       ebreak,
  output logic       trap
);

  // --------------------------------------------------------------------------
  // Data memory port
  // --------------------------------------------------------------------------

  // Execute result is the effective address
  assign dmem_raddr = ex.result;
  assign dmem_waddr = ex.result;
  assign dmem_wdata = ex.store_data;
  assign dmem_wstrb = 4'b1111;

  // One-cycle strobes, silenced after halt
  assign dmem_ren = ex.mem_read && !halted;
  assign dmem_we  = ex.mem_write && !halted;

  // Register write, load data arrives in the same cycle
  assign rf_wr.we   = ex.reg_write && !halted;
  assign rf_wr.rd   = ex.rd;
  assign rf_wr.data = ex.mem_read ? dmem_rdata : ex.result;

  // --------------------------------------------------------------------------
  // Sticky halt flags
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else if (!halted) begin
      halted <= ex.is_ebreak || ex.illegal;
      ebreak <= ex.is_ebreak;
      trap   <= ex.illegal;
    end
  end

  // Once halted, no memory access or register write leaves the core
  assert property (@(posedge clk) disable iff (!rst_n)
                   halted |-> !(dmem_we || dmem_ren || rf_wr.we))
    else $error("rv_writeback: write activity after halt");

endmodule

`default_nettype wire
